//--- mips_core_settings.svh
`ifndef MIPS_CORE_SETTINGS_SVH
`define MIPS_CORE_SETTINGS_SVH

// Datapath and address width
`define DATA_W 32

// Architectural registers, numbered with 5 bits
`define REG_NUM 32

// Boot vector of the first fetch
`define RESET_PC 32'hBFC0_0000

// Extra cycles the core stays in reset once the external reset drops
`define RST_HOLD 16

`endif

//--- mips_pkg.sv
`include "mips_core_settings.svh"

package mips_pkg;

    localparam int REG_COUNT   = `REG_NUM;
    localparam int HOLD_CYCLES = `RST_HOLD;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [$clog2(`REG_NUM)-1:0] reg_num_t;

    // Major opcodes handled by the core
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_SLTIU   = 6'h0B,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F
    } opcode_e;

    // SPECIAL function field
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // Decode to execute
    typedef struct packed {
        logic     valid;
        word_t    pc;
        alu_op_e  alu_op;
        reg_num_t rs_num;
        word_t    rs_val;
        reg_num_t rt_num;
        word_t    rt_val;
        logic     use_imm;
        word_t    imm;
        logic [4:0] shamt;
        logic     wr_en;
        reg_num_t rd_num;
    } dec_bundle_t;

    // Write-back register, also the debug port
    typedef struct packed {
        word_t    pc;
        logic [3:0] wen;
        reg_num_t num;
        word_t    data;
    } wb_bundle_t;

endpackage

//--- reset_stretcher.sv
`timescale 1ns/1ps

module reset_stretcher
    import mips_pkg::*;
(
    input  logic Clk,
    input  logic Myreset,
    output logic o_core_rst
);

    localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

    logic [CNT_W-1:0] hold_cnt;

    // Counter restarts on every external reset cycle
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            hold_cnt   <= '0;
            o_core_rst <= 1'b1;
        end else if (o_core_rst) begin
            if (hold_cnt == CNT_W'(HOLD_CYCLES - 1)) begin
                o_core_rst <= 1'b0;
            end
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

endmodule

//--- fetch_decode.sv
`timescale 1ns/1ps
`include "mips_core_settings.svh"

module fetch_decode
    import mips_pkg::*;
(
    input  logic        Clk,
    input  logic        i_rst,
    input  logic        i_inst_valid,
    input  word_t       i_inst_data,
    output logic        o_inst_req,
    output word_t       o_inst_addr,
    output reg_num_t    o_rs_num,
    output reg_num_t    o_rt_num,
    input  word_t       i_rs_val,
    input  word_t       i_rt_val,
    output dec_bundle_t o_dec
);

    typedef enum logic [1:0] {
        IMM_SIGN,
        IMM_ZERO,
        IMM_UPPER
    } imm_kind_e;

    logic               req_q;
    logic [`DATA_W-1:0] pc_q;
    logic               accept;
    logic               dec_valid_q;
    word_t              dec_pc_q;
    word_t              dec_inst_q;

    opcode_e   opcode;
    funct_e    funct;
    imm_kind_e imm_kind;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      wr_en;
    reg_num_t  dest;
    word_t     imm_ext;

    assign accept      = req_q && i_inst_valid;
    assign o_inst_req  = req_q;
    assign o_inst_addr = pc_q;

    always_ff @(posedge Clk) begin
        if (i_rst) begin
            req_q       <= 1'b0;
            pc_q        <= `RESET_PC;
            dec_valid_q <= 1'b0;
        end else begin
            req_q       <= 1'b1;
            // Empty slot when the supply side has nothing
            dec_valid_q <= accept;
            if (accept) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            dec_inst_q <= i_inst_data;
            dec_pc_q   <= pc_q;
        end
    end

    assign opcode   = opcode_e'(dec_inst_q[31:26]);
    assign funct    = funct_e'(dec_inst_q[5:0]);
    assign o_rs_num = dec_inst_q[25:21];
    assign o_rt_num = dec_inst_q[20:16];

    always_comb begin
        alu_op   = ALU_ADD;
        use_imm  = 1'b1;
        imm_kind = IMM_SIGN;
        wr_en    = 1'b1;
        dest     = dec_inst_q[20:16];
        case (opcode)
            OP_SPECIAL: begin
                use_imm = 1'b0;
                dest    = dec_inst_q[15:11];
                case (funct)
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    default: wr_en = 1'b0;
                endcase
            end
            OP_ADDIU: alu_op = ALU_ADD;
            OP_SLTI:  alu_op = ALU_SLT;
            OP_SLTIU: alu_op = ALU_SLTU;
            OP_ANDI: begin
                alu_op   = ALU_AND;
                imm_kind = IMM_ZERO;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                imm_kind = IMM_ZERO;
            end
            OP_XORI: begin
                alu_op   = ALU_XOR;
                imm_kind = IMM_ZERO;
            end
            OP_LUI: begin
                alu_op   = ALU_LUI;
                imm_kind = IMM_UPPER;
            end
            // Retires silently
            default: wr_en = 1'b0;
        endcase
    end

    always_comb begin
        case (imm_kind)
            IMM_ZERO:  imm_ext = {16'h0000, dec_inst_q[15:0]};
            IMM_UPPER: imm_ext = {dec_inst_q[15:0], 16'h0000};
            default:   imm_ext = {{16{dec_inst_q[15]}}, dec_inst_q[15:0]};
        endcase
    end

    always_comb begin
        o_dec.valid   = dec_valid_q;
        o_dec.pc      = dec_pc_q;
        o_dec.alu_op  = alu_op;
        o_dec.rs_num  = o_rs_num;
        o_dec.rs_val  = i_rs_val;
        o_dec.rt_num  = o_rt_num;
        o_dec.rt_val  = i_rt_val;
        o_dec.use_imm = use_imm;
        o_dec.imm     = imm_ext;
        o_dec.shamt   = dec_inst_q[10:6];
        // r0 is never a real destination
        o_dec.wr_en   = wr_en && (dest != '0);
        o_dec.rd_num  = dest;
    end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file
    import mips_pkg::*;
(
    input  logic       Clk,
    input  reg_num_t   i_rs_num,
    input  reg_num_t   i_rt_num,
    output word_t      o_rs_val,
    output word_t      o_rt_val,
    input  wb_bundle_t i_wb
);

    word_t regs [REG_COUNT];
    logic  wr;

    assign wr = |i_wb.wen;

    always_ff @(posedge Clk) begin
        if (wr) begin
            regs[i_wb.num] <= i_wb.data;
        end
    end

    // Same-cycle write is visible to the reader
    function automatic word_t read_port(input reg_num_t num);
        word_t val;
        if (num == '0) begin
            val = '0;
        end else if (wr && (i_wb.num == num)) begin
            val = i_wb.data;
        end else begin
            val = regs[num];
        end
        return val;
    endfunction

    always_comb begin
        o_rs_val = read_port(i_rs_num);
        o_rt_val = read_port(i_rt_num);
    end

endmodule

//--- exec_stage.sv
`timescale 1ns/1ps
`include "mips_core_settings.svh"

module exec_stage
    import mips_pkg::*;
(
    input  logic        Clk,
    input  logic        i_rst,
    input  dec_bundle_t i_dec,
    output wb_bundle_t  o_wb
);

    logic [3:0] wen_q;
    word_t      pc_q;
    reg_num_t   num_q;
    word_t      data_q;

    logic  pending;
    word_t op_a;
    word_t rt_fwd;
    word_t op_b;
    word_t result;

    assign pending = |wen_q;

    // Take the write-back value over a stale register read
    function automatic word_t forward(input reg_num_t num, input word_t val);
        word_t sel;
        if (pending && (num_q == num)) begin
            sel = data_q;
        end else begin
            sel = val;
        end
        return sel;
    endfunction

    always_comb begin
        op_a   = forward(i_dec.rs_num, i_dec.rs_val);
        rt_fwd = forward(i_dec.rt_num, i_dec.rt_val);
        op_b   = i_dec.use_imm ? i_dec.imm : rt_fwd;
    end

    always_comb begin
        case (i_dec.alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_NOR:  result = ~(op_a | op_b);
            ALU_SLT:  result = {{(`DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {{(`DATA_W-1){1'b0}}, op_a < op_b};
            // Shifts take rt and the shamt field
            ALU_SLL:  result = op_b << i_dec.shamt;
            ALU_SRL:  result = op_b >> i_dec.shamt;
            ALU_SRA:  result = word_t'($signed(op_b) >>> i_dec.shamt);
            ALU_LUI:  result = op_b;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (i_rst) begin
            wen_q <= 4'b0000;
        end else begin
            wen_q <= (i_dec.valid && i_dec.wr_en) ? 4'b1111 : 4'b0000;
        end
    end

    always_ff @(posedge Clk) begin
        pc_q   <= i_dec.pc;
        num_q  <= i_dec.rd_num;
        data_q <= result;
    end

    always_comb begin
        o_wb.pc   = pc_q;
        o_wb.wen  = wen_q;
        o_wb.num  = num_q;
        o_wb.data = data_q;
    end

endmodule

//--- mips_core.sv
`timescale 1ns/1ps

module mips_core
    import mips_pkg::*;
(
    input  logic       Clk,
    input  logic       Myreset,
    input  logic       i_inst_valid,
    input  word_t      i_inst_data,
    output logic       o_inst_req,
    output word_t      o_inst_addr,
    output wb_bundle_t o_wb
);

    logic        core_rst;
    reg_num_t    rs_num;
    reg_num_t    rt_num;
    word_t       rs_val;
    word_t       rt_val;
    dec_bundle_t dec;

    reset_stretcher u_reset_stretcher (
        .Clk        (Clk),
        .Myreset    (Myreset),
        .o_core_rst (core_rst)
    );

    fetch_decode u_fetch_decode (
        .Clk          (Clk),
        .i_rst        (core_rst),
        .i_inst_valid (i_inst_valid),
        .i_inst_data  (i_inst_data),
        .o_inst_req   (o_inst_req),
        .o_inst_addr  (o_inst_addr),
        .o_rs_num     (rs_num),
        .o_rt_num     (rt_num),
        .i_rs_val     (rs_val),
        .i_rt_val     (rt_val),
        .o_dec        (dec)
    );

    // Write port is the write-back register itself
    reg_file u_reg_file (
        .Clk      (Clk),
        .i_rs_num (rs_num),
        .i_rt_num (rt_num),
        .o_rs_val (rs_val),
        .o_rt_val (rt_val),
        .i_wb     (o_wb)
    );

    exec_stage u_exec_stage (
        .Clk   (Clk),
        .i_rst (core_rst),
        .i_dec (dec),
        .o_wb  (o_wb)
    );

endmodule

//--- tb_mips_core.sv
`timescale 1ns/1ps
`include "mips_core_settings.svh"

module tb_mips_core
    import mips_pkg::*;
();

    localparam int    CLK_PERIOD = 20;
    localparam string TEST_FILE  = "mips_tests.txt";

    logic       Clk;
    logic       Myreset;
    logic       i_inst_valid;
    word_t      i_inst_data;
    logic       o_inst_req;
    word_t      o_inst_addr;
    wb_bundle_t o_wb;

    word_t t_inst[$];
    bit    t_wr[$];
    int    t_reg[$];
    word_t t_data[$];
    string t_name[$];
    bit    fetch_ok[$];

    int          num_tests    = 0;
    int          writes_left  = 0;
    int          head         = 0;
    int          errors       = 0;
    int          ok_count     = 0;
    int          bad_count    = 0;
    int          watch_cycles = 0;
    bit          loaded       = 1'b0;
    bit          collecting   = 1'b0;
    logic [31:0] rng;

    mips_core UUT (
        .Clk          (Clk),
        .Myreset      (Myreset),
        .i_inst_valid (i_inst_valid),
        .i_inst_data  (i_inst_data),
        .o_inst_req   (o_inst_req),
        .o_inst_addr  (o_inst_addr),
        .o_wb         (o_wb)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Each line is one word, so PCs follow the line index
    function automatic word_t pc_of(input int idx);
        return `RESET_PC + 32'(4 * idx);
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual,
                               inout bit ok);
        if (expected !== actual) begin
            $display("Error: test %0s, %0s expected %h, actual %h",
                     name, what, expected, actual);
            errors++;
            ok = 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input bit ok);
        if (ok) begin
            ok_count++;
            $display("Test %0s: ok", name);
        end else begin
            bad_count++;
            $display("Test %0s: mismatch", name);
        end
    endtask

    task automatic load_tests(output bit ok);
        int    fd;
        int    n;
        int    wr;
        int    reg_num;
        word_t word;
        word_t data;
        string name;
        string line;
        ok = 1'b0;
        fd = $fopen(TEST_FILE, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                n = 0;
                if (line.len() >= 2 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%h %d %d %h %s", word, wr, reg_num, data, name);
                end
                if (n == 5) begin
                    t_inst.push_back(word);
                    t_wr.push_back(wr != 0);
                    t_reg.push_back(reg_num);
                    t_data.push_back(data);
                    t_name.push_back(name);
                    fetch_ok.push_back(1'b1);
                    if (wr != 0) begin
                        writes_left++;
                    end
                end
            end
            $fclose(fd);
            num_tests = t_inst.size();
            ok = (num_tests > 0);
        end
    endtask

    task automatic check_reset();
        bit ok;
        int k;
        ok = 1'b1;
        for (k = 0; k < 4; k++) begin
            @(posedge Clk);
            @(negedge Clk);
            // Stretched reset reaches the stages one edge late
            if (k > 0) begin
                check_value("reset_hold", "request", 32'd0, {31'd0, o_inst_req}, ok);
                check_value("reset_hold", "write enable", 32'd0, {28'd0, o_wb.wen}, ok);
            end
        end
        Myreset = 1'b0;
        for (k = 0; k < `RST_HOLD; k++) begin
            @(posedge Clk);
            @(negedge Clk);
            check_value("reset_hold", "request", 32'd0, {31'd0, o_inst_req}, ok);
            check_value("reset_hold", "write enable", 32'd0, {28'd0, o_wb.wen}, ok);
        end
        @(posedge Clk);
        @(negedge Clk);
        check_value("reset_hold", "request", 32'd1, {31'd0, o_inst_req}, ok);
        check_value("reset_hold", "first address", `RESET_PC, o_inst_addr, ok);
        finish_test("reset_hold", ok);
    endtask

    // Offers one word per test after a random idle gap
    task automatic run_program();
        int i;
        int gap;
        bit ok;
        for (i = 0; i < num_tests; i++) begin
            rng = xorshift32(rng);
            gap = {30'd0, rng[1:0]};
            repeat (gap) @(negedge Clk);
            ok = 1'b1;
            check_value(t_name[i], "fetch request", 32'd1, {31'd0, o_inst_req}, ok);
            check_value(t_name[i], "fetch address", pc_of(i), o_inst_addr, ok);
            fetch_ok[i] = ok;
            i_inst_valid = 1'b1;
            i_inst_data  = t_inst[i];
            @(negedge Clk);
            i_inst_valid = 1'b0;
            i_inst_data  = '0;
        end
    endtask

    task automatic take_writeback(input wb_bundle_t wb);
        bit ok;
        // Silent tests older than this write-back are done
        while (head < num_tests && !t_wr[head] && pc_of(head) != wb.pc) begin
            finish_test(t_name[head], fetch_ok[head]);
            head++;
        end
        if (head >= num_tests) begin
            $display("Write-back to register %0d from PC %h came after the last test",
                     wb.num, wb.pc);
            errors++;
        end else if (!t_wr[head]) begin
            $display("Test %0s wrote register %0d although it must not write",
                     t_name[head], wb.num);
            errors++;
            finish_test(t_name[head], 1'b0);
            head++;
        end else begin
            ok = fetch_ok[head];
            check_value(t_name[head], "pc", pc_of(head), wb.pc, ok);
            check_value(t_name[head], "write enable", 32'h0000_000F, {28'd0, wb.wen}, ok);
            check_value(t_name[head], "register", t_reg[head], {27'd0, wb.num}, ok);
            check_value(t_name[head], "data", t_data[head], wb.data, ok);
            finish_test(t_name[head], ok);
            head++;
            writes_left--;
        end
    endtask

    initial begin
        wait (collecting);
        forever begin
            @(negedge Clk);
            if (o_wb.wen != 4'b0000) begin
                take_writeback(o_wb);
            end
        end
    end

    initial begin
        wait (loaded);
        #(watch_cycles * CLK_PERIOD);
        $display("Timeout: retirements stopped arriving before all tests finished");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        bit ok;
        Myreset      = 1'b1;
        i_inst_valid = 1'b0;
        i_inst_data  = '0;
        rng          = 32'hb83f09d1;
        load_tests(ok);
        if (!ok) begin
            $display("Could not read any test from %0s", TEST_FILE);
            $display("Testbench failed");
            $finish;
        end else begin
            watch_cycles = num_tests * 8 + `RST_HOLD + 20;
            loaded = 1'b1;
            check_reset();
            collecting = 1'b1;
            run_program();
            wait (writes_left == 0);
            repeat (4) @(posedge Clk);
            // Silent tests at the tail
            while (head < num_tests) begin
                finish_test(t_name[head], fetch_ok[head]);
                head++;
            end
            $display("Tests: %0d run, %0d ok, %0d bad, %0d errors",
                     ok_count + bad_count, ok_count, bad_count, errors);
            if (errors == 0 && bad_count == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

//--- mips_core.f
+incdir+.
mips_pkg.sv
reset_stretcher.sv
fetch_decode.sv
reg_file.sv
exec_stage.sv
mips_core.sv
tb_mips_core.sv

//--- Makefile
# Verilator build and run of the core testbench
TOP       ?= tb_mips_core
FILELIST  ?= mips_core.f
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

# Fails unless the pass line shows up in the simulation output
sim:
	$(VERILATOR) --binary -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- mips_tests.txt
// word write reg data name
// word and data in hex, write flag and register number in decimal
24010005 1 1 00000005 addiu_pos
2422FFFD 1 2 00000002 addiu_neg_dist1
3C038001 1 3 80010000 lui_upper
3464F0F0 1 4 8001F0F0 ori_dist1
3085FF00 1 5 0000F000 andi_zero_ext
3886FFFF 1 6 80010F0F xori_dist2
00223821 1 7 00000007 addu_regs
00414023 1 8 FFFFFFFD subu_wrap
00864824 1 9 80010000 and_regs
00865025 1 10 8001FFFF or_regs
00865826 1 11 0000FFFF xor_regs
01416027 1 12 7FFE0000 nor_dist2
0101682A 1 13 00000001 slt_signed
0101702B 1 14 00000000 sltu_unsigned
290FFFFE 1 15 00000001 slti_neg
2C30FFFF 1 16 00000001 sltiu_sext
00018900 1 17 00000050 sll_by4
00039202 1 18 00800100 srl_by8
00039A03 1 19 FF800100 sra_by8
0013A7C3 1 20 FFFFFFFF sra_dist1
24201234 0 0 00000000 addiu_to_r0
8C350000 0 0 00000000 lw_unsupported
00220018 0 0 00000000 mult_unsupported
341500AA 1 21 000000AA ori_from_r0
0001B021 1 22 00000005 addu_from_r0
02B6B823 1 23 000000A5 subu_dist1_dist2
24210001 1 1 00000006 addiu_overwrite
0021C021 1 24 0000000C addu_same_src
